/* Makefile */
SIM := obj_dir/Vtb_spi_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_spi_top -f tb.f

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* hw/sd_spi_top.sv */
`timescale 1ns/1ps

module sd_spi_top
    import spi_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    // Command side.
    input  logic                 cmd_valid_i,
    input  logic                 cmd_write_i,
    input  logic [WORD_BITS-1:0] cmd_addr_i,
    input  logic [WORD_BITS-1:0] wr_data_i,
    output logic                 ready_o,
    output logic                 done_o,
    output logic [WORD_BITS-1:0] rd_data_o,
    // SPI pins.
    output logic                 sclk_o,
    output logic                 mosi_o,
    output logic                 cs_n_o,
    input  logic                 miso_i
);

    logic       run;
    logic       fast;
    logic       rise;
    logic       fall;
    logic       load;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    logic       byte_done;

    // Sequencing of wait, init clocks and command frames.
    spi_master_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid_i),
        .cmd_write_i (cmd_write_i),
        .cmd_addr_i  (cmd_addr_i),
        .wr_data_i   (wr_data_i),
        .rise_i      (rise),
        .byte_done_i (byte_done),
        .rx_byte_i   (rx_byte),
        .ready_o     (ready_o),
        .done_o      (done_o),
        .rd_data_o   (rd_data_o),
        .run_o       (run),
        .fast_o      (fast),
        .cs_n_o      (cs_n_o),
        .load_o      (load),
        .tx_byte_o   (tx_byte)
    );

    // SPI clock and edge ticks.
    spi_clock_gen u_clk_gen (
        .clk    (clk),
        .rst    (rst),
        .run_i  (run),
        .fast_i (fast),
        .sclk_o (sclk_o),
        .rise_o (rise),
        .fall_o (fall)
    );

    // Byte-wide data path.
    spi_shifter u_shifter (
        .clk         (clk),
        .rst         (rst),
        .load_i      (load),
        .tx_byte_i   (tx_byte),
        .rise_i      (rise),
        .fall_i      (fall),
        .miso_i      (miso_i),
        .mosi_o      (mosi_o),
        .rx_byte_o   (rx_byte),
        .byte_done_o (byte_done)
    );

endmodule

/* hw/spi_clock_gen.sv */
`timescale 1ns/1ps

module spi_clock_gen
    import spi_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic run_i,
    input  logic fast_i,
    output logic sclk_o,
    output logic rise_o,
    output logic fall_o
);

    // Counts down the current half period.
    logic [3:0] half_cnt;
    logic [3:0] half_reload;

    // Last count of a half period for the selected rate.
    assign half_reload = fast_i ? 4'(DIV_FAST - 1) : 4'(DIV_SLOW - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            half_cnt <= 4'(DIV_SLOW - 1);
            sclk_o   <= 1'b0;
            rise_o   <= 1'b0;
            fall_o   <= 1'b0;
        end else begin
            rise_o <= 1'b0;
            fall_o <= 1'b0;
            if (!run_i) begin
                // Idle low and primed so the first half period is a full one.
                half_cnt <= half_reload;
                sclk_o   <= 1'b0;
            end else if (half_cnt == '0) begin
                half_cnt <= half_reload;
                sclk_o   <= ~sclk_o;
                // Ticks line up with the cycle the new level appears.
                rise_o   <= ~sclk_o;
                fall_o   <= sclk_o;
            end else begin
                half_cnt <= half_cnt - 4'd1;
            end
        end
    end

endmodule

/* hw/spi_master_ctrl.sv */
`timescale 1ns/1ps

module spi_master_ctrl
    import spi_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid_i,
    input  logic                 cmd_write_i,
    input  logic [WORD_BITS-1:0] cmd_addr_i,
    input  logic [WORD_BITS-1:0] wr_data_i,
    input  logic                 rise_i,
    input  logic                 byte_done_i,
    input  logic [7:0]           rx_byte_i,
    output logic                 ready_o,
    output logic                 done_o,
    output logic [WORD_BITS-1:0] rd_data_o,
    output logic                 run_o,
    output logic                 fast_o,
    output logic                 cs_n_o,
    output logic                 load_o,
    output logic [7:0]           tx_byte_o
);

    ctrl_state_e state;

    // Power-up wait counter, reused for the tail of the last init clock.
    logic [7:0] wait_cnt;
    // Rising edges sent during init.
    logic [6:0] init_cnt;
    // Opcode in the top byte, then address and data.
    logic [8*FRAME_BYTES-1:0] frame_q;
    logic [3:0] byte_idx;
    logic [WORD_BITS-1:0] rd_acc;
    spi_op_e op_sel;
    logic is_read;

    assign op_sel  = cmd_write_i ? OP_WRITE : OP_READ;
    assign is_read = (frame_q[8*FRAME_BYTES-1 -: 8] == OP_READ);

    // Byte 0 is the opcode, sent first.
    assign tx_byte_o = frame_q[8 * (FRAME_BYTES - 1 - byte_idx) +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_POWER_WAIT;
            wait_cnt <= '0;
            init_cnt <= '0;
            byte_idx <= '0;
            ready_o  <= 1'b0;
            done_o   <= 1'b0;
            run_o    <= 1'b0;
            fast_o   <= 1'b0;
            cs_n_o   <= 1'b1;
            load_o   <= 1'b0;
        end else begin
            load_o <= 1'b0;
            case (state)
                ST_POWER_WAIT: begin
                    if (wait_cnt == 8'(WAIT_CYCLES - 1)) begin
                        wait_cnt <= '0;
                        run_o    <= 1'b1;
                        state    <= ST_INIT_CLK;
                    end else begin
                        wait_cnt <= wait_cnt + 8'd1;
                    end
                end
                ST_INIT_CLK: begin
                    if (init_cnt != 7'(INIT_CLOCKS)) begin
                        if (rise_i) begin
                            init_cnt <= init_cnt + 7'd1;
                        end
                    end else if (wait_cnt == 8'(DIV_SLOW - 3)) begin
                        // Timed so the clock drops at the end of its
                        // last full high half.
                        run_o   <= 1'b0;
                        fast_o  <= 1'b1;
                        ready_o <= 1'b1;
                        state   <= ST_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 8'd1;
                    end
                end
                ST_IDLE: begin
                    if (cmd_valid_i && ready_o) begin
                        frame_q  <= {op_sel, cmd_addr_i, wr_data_i};
                        byte_idx <= '0;
                        ready_o  <= 1'b0;
                        cs_n_o   <= 1'b0;
                        run_o    <= 1'b1;
                        load_o   <= 1'b1;
                        state    <= ST_FRAME;
                    end
                end
                ST_FRAME: begin
                    if (byte_done_i) begin
                        // Last four bytes carry the read word, MSB first.
                        if (is_read && byte_idx >= 4'(FRAME_BYTES - 4)) begin
                            rd_acc <= {rd_acc[WORD_BITS-9:0], rx_byte_i};
                        end
                        if (byte_idx == 4'(FRAME_BYTES - 1)) begin
                            cs_n_o <= 1'b1;
                            run_o  <= 1'b0;
                            state  <= ST_DONE;
                        end else begin
                            byte_idx <= byte_idx + 4'd1;
                            load_o   <= 1'b1;
                        end
                    end
                end
                ST_DONE: begin
                    // First cycle raises done and the second returns to idle.
                    if (!done_o) begin
                        done_o <= 1'b1;
                    end else begin
                        done_o  <= 1'b0;
                        ready_o <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_POWER_WAIT;
                end
            endcase
        end
    end

    // Read result is published together with done.
    always_ff @(posedge clk) begin
        if (state == ST_DONE && !done_o && is_read) begin
            rd_data_o <= rd_acc;
        end
    end

endmodule

/* hw/spi_pkg.sv */
package spi_pkg;

    // Power-up wait in system clocks, scaled down from 1 ms.
    localparam int unsigned WAIT_CYCLES = 200;

    // SPI clock periods sent with chip select high before the first command.
    localparam int unsigned INIT_CLOCKS = 80;

    // SPI half periods in system clocks.
    // The slow rate stands in for the 400 kHz init clock.
    localparam int unsigned DIV_SLOW = 8;
    localparam int unsigned DIV_FAST = 2;

    // Address and data word width.
    localparam int unsigned WORD_BITS = 32;

    // Opcode byte, four address bytes, four data bytes.
    localparam int unsigned FRAME_BYTES = 9;

    // Opcode byte sent first in every frame.
    typedef enum logic [7:0] {
        OP_WRITE = 8'h02,
        OP_READ  = 8'h03
    } spi_op_e;

    // Controller states.
    typedef enum logic [2:0] {
        ST_POWER_WAIT,
        ST_INIT_CLK,
        ST_IDLE,
        ST_FRAME,
        ST_DONE
    } ctrl_state_e;

endpackage

/* hw/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter (
    input  logic       clk,
    input  logic       rst,
    input  logic       load_i,
    input  logic [7:0] tx_byte_i,
    input  logic       rise_i,
    input  logic       fall_i,
    input  logic       miso_i,
    output logic       mosi_o,
    output logic [7:0] rx_byte_o,
    output logic       byte_done_o
);

    // Transmit bits leave from the top.
    logic [7:0] tx_sr;
    logic [7:0] rx_sr;
    // Rising edges seen in the current byte.
    logic [2:0] bit_cnt;
    // High from load until the eighth rising edge.
    logic       active;

    // Mode 0, so the MSB is on the line as soon as the byte is loaded.
    assign mosi_o = tx_sr[7];

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_sr       <= '0;
            bit_cnt     <= '0;
            active      <= 1'b0;
            byte_done_o <= 1'b0;
        end else begin
            byte_done_o <= 1'b0;
            if (load_i) begin
                tx_sr   <= tx_byte_i;
                bit_cnt <= '0;
                active  <= 1'b1;
            end else if (active) begin
                // A falling edge before the first rise is the tail of the
                // previous byte and must not move the new MSB.
                if (fall_i && bit_cnt != '0) begin
                    tx_sr <= {tx_sr[6:0], 1'b0};
                end
                if (rise_i) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        active      <= 1'b0;
                        byte_done_o <= 1'b1;
                    end
                end
            end
        end
    end

    // Receive path.
    // Sampled on the rising tick, a full half period after the slave
    // changed MISO.
    always_ff @(posedge clk) begin
        if (active && rise_i) begin
            rx_sr <= {rx_sr[6:0], miso_i};
            if (bit_cnt == 3'd7) begin
                rx_byte_o <= {rx_sr[6:0], miso_i};
            end
        end
    end

endmodule

/* tb.f */
hw/spi_pkg.sv
hw/spi_clock_gen.sv
hw/spi_shifter.sv
hw/spi_master_ctrl.sv
hw/sd_spi_top.sv
test/spi_mem_model.sv
test/tb_spi_top.sv

/* test/spi_mem_model.sv */
`timescale 1ns/1ps

module spi_mem_model
    import spi_pkg::*;
(
    input  logic        sclk_i,
    input  logic        mosi_i,
    input  logic        cs_n_i,
    output logic        miso_o,
    output logic [31:0] init_edges_o,
    output logic [31:0] high_ns_o
);

    localparam int unsigned DEPTH      = 16;
    localparam int unsigned FRAME_BITS = 8 * FRAME_BYTES;
    // The read word follows the opcode and address.
    localparam int unsigned HEAD_BITS  = 8 + WORD_BITS;

    logic [WORD_BITS-1:0]  mem [DEPTH];
    logic [FRAME_BITS-1:0] rx_sr;
    logic [WORD_BITS-1:0]  rd_word;
    logic [4:0]            rd_pos;
    int unsigned           bit_cnt = 0;
    logic                  reading = 1'b0;
    // The first chip select ends the init measurement.
    logic                  seen_cs = 1'b0;
    time                   high_start = 0;
    time                   high_len = 0;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'h5A5A_0000 + 32'(i);
        end
        miso_o       = 1'b0;
        init_edges_o = '0;
        high_ns_o    = '0;
    end

    // In mode 0 MOSI is stable on the rising edge.
    always @(posedge sclk_i) begin
        if (cs_n_i) begin
            init_edges_o = init_edges_o + 32'd1;
            high_start   = $time;
        end else begin
            rx_sr   = {rx_sr[FRAME_BITS-2:0], mosi_i};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == HEAD_BITS) begin
                // Address is complete.
                // Fetch now so the first data bit goes out on the next fall.
                reading = (rx_sr[WORD_BITS +: 8] == OP_READ);
                rd_word = mem[rx_sr[3:0]];
            end
            if (bit_cnt == FRAME_BITS) begin
                if (rx_sr[FRAME_BITS-1 -: 8] == OP_WRITE) begin
                    mem[rx_sr[WORD_BITS+3:WORD_BITS]] = rx_sr[WORD_BITS-1:0];
                end
                bit_cnt = 0;
                reading = 1'b0;
            end
        end
    end

    // MISO changes on falling edges and when chip select falls.
    always @(negedge sclk_i or negedge cs_n_i) begin
        if (!cs_n_i) begin
            seen_cs = 1'b1;
        end else if (!seen_cs && init_edges_o != 0 && ($time - high_start) > high_len) begin
            // Longest high half of the init clock.
            high_len  = $time - high_start;
            high_ns_o = 32'(high_len);
        end
        if (reading && bit_cnt >= HEAD_BITS && bit_cnt < FRAME_BITS) begin
            rd_pos = 5'(FRAME_BITS - 1 - bit_cnt);
            miso_o = rd_word[rd_pos];
        end else begin
            miso_o = 1'b0;
        end
    end

endmodule

/* test/tb_spi_top.sv */
`timescale 1ns/1ps

module tb_spi_top
    import spi_pkg::*;
();

    localparam int unsigned CLK_PERIOD   = 20;
    localparam int unsigned RESET_CYCLES = 10;
    localparam int unsigned MEM_DEPTH    = 16;
    localparam int unsigned NUM_TESTS    = 14;
    // Nominal frame and init lengths in system clocks.
    localparam int unsigned FRAME_CYCLES = FRAME_BYTES * 8 * 2 * DIV_FAST;
    localparam int unsigned INIT_CYCLES  = WAIT_CYCLES + INIT_CLOCKS * 2 * DIV_SLOW;
    // Low half after the last init rise may overlap idle.
    localparam int unsigned READY_MIN    = WAIT_CYCLES + (2 * INIT_CLOCKS - 1) * DIV_SLOW;
    localparam int unsigned WATCHDOG_CYCLES =
        RESET_CYCLES + INIT_CYCLES + NUM_TESTS * 2 * FRAME_CYCLES;
    // Target of the strobe sent while the master is busy.
    localparam logic [WORD_BITS-1:0] POKE_ADDR = 32'h0000_0007;
    localparam logic [WORD_BITS-1:0] POKE_DATA = 32'h0BAD_0BAD;

    logic                 clk;
    logic                 rst;
    logic                 cmd_valid;
    logic                 cmd_write;
    logic [WORD_BITS-1:0] cmd_addr;
    logic [WORD_BITS-1:0] wr_data;
    logic                 ready;
    logic                 done;
    logic [WORD_BITS-1:0] rd_data;
    logic                 sclk;
    logic                 mosi;
    logic                 cs_n;
    logic                 miso;
    logic [31:0]          init_edges;
    logic [31:0]          high_ns;

    // Stimulus table with one column per array.
    logic                 tbl_write  [NUM_TESTS];
    logic [WORD_BITS-1:0] tbl_addr   [NUM_TESTS];
    logic [WORD_BITS-1:0] tbl_wdata  [NUM_TESTS];
    logic                 tbl_poke   [NUM_TESTS];
    logic [WORD_BITS-1:0] tbl_expect [NUM_TESTS];
    logic [WORD_BITS-1:0] ref_mem    [MEM_DEPTH];

    int unsigned error_count = 0;
    int unsigned test_count = 0;
    int unsigned test_fails = 0;
    int unsigned done_seen = 0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    sd_spi_top DUT (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid),
        .cmd_write_i (cmd_write),
        .cmd_addr_i  (cmd_addr),
        .wr_data_i   (wr_data),
        .ready_o     (ready),
        .done_o      (done),
        .rd_data_o   (rd_data),
        .sclk_o      (sclk),
        .mosi_o      (mosi),
        .cs_n_o      (cs_n),
        .miso_i      (miso)
    );

    spi_mem_model u_mem (
        .sclk_i       (sclk),
        .mosi_i       (mosi),
        .cs_n_i       (cs_n),
        .miso_o       (miso),
        .init_edges_o (init_edges),
        .high_ns_o    (high_ns)
    );

    // Every done pulse, expected or not.
    always @(negedge clk) begin
        if (!rst && done) begin
            done_seen <= done_seen + 1;
        end
    end

    task automatic check_word(input string name, input logic [WORD_BITS-1:0] got,
                              input logic [WORD_BITS-1:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got,
                     expected);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got,
                     expected);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int unsigned errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("Test %0d %s: passed", test_count, name);
        end else begin
            test_fails++;
            $display("Test %0d %s: FAILED", test_count, name);
        end
    endtask

    task automatic add_entry(input int unsigned idx, input logic write,
                             input logic [WORD_BITS-1:0] addr,
                             input logic [WORD_BITS-1:0] wdata, input logic poke);
        tbl_write[idx] = write;
        tbl_addr[idx]  = addr;
        tbl_wdata[idx] = wdata;
        tbl_poke[idx]  = poke;
    endtask

    task automatic build_table();
        add_entry(0, 1'b0, 32'h0000_0000, '0, 1'b0);
        add_entry(1, 1'b0, 32'h0000_0005, '0, 1'b0);
        add_entry(2, 1'b0, 32'h0000_000F, '0, 1'b0);
        // Upper address bits do not select the word.
        add_entry(3, 1'b0, 32'h0000_0013, '0, 1'b0);
        add_entry(4, 1'b0, 32'hFFFF_FFFC, '0, 1'b0);
        add_entry(5, 1'b1, 32'h0000_0005, 32'h1234_5678, 1'b0);
        add_entry(6, 1'b0, 32'h0000_0005, '0, 1'b0);
        // Neighbours of the written word.
        add_entry(7, 1'b0, 32'h0000_0004, '0, 1'b0);
        add_entry(8, 1'b0, 32'h0000_0006, '0, 1'b0);
        add_entry(9, 1'b1, 32'h0000_000A, 32'hCAFE_F00D, 1'b1);
        add_entry(10, 1'b0, POKE_ADDR, '0, 1'b0);
        add_entry(11, 1'b0, 32'h0000_000A, '0, 1'b0);
        add_entry(12, 1'b1, 32'h0000_0000, 32'hA5C3_3C5A, 1'b0);
        add_entry(13, 1'b0, 32'h0000_0010, '0, 1'b0);
    endtask

    // Walks the table against a reference memory.
    task automatic fill_expected();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            ref_mem[i] = 32'h5A5A_0000 + 32'(i);
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (tbl_write[i]) begin
                ref_mem[tbl_addr[i][3:0]] = tbl_wdata[i];
                tbl_expect[i] = '0;
            end else begin
                tbl_expect[i] = ref_mem[tbl_addr[i][3:0]];
            end
        end
    endtask

    // Polls on falling edges and gives up after limit cycles.
    task automatic wait_for(input logic want_done, input int unsigned limit,
                            output int unsigned cycles, output logic seen);
        cycles = 0;
        seen = want_done ? done : ready;
        while (seen !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
            seen = want_done ? done : ready;
        end
        seen = (seen === 1'b1);
    endtask

    task automatic run_entry(input int unsigned idx);
        int unsigned cycles;
        logic        seen;
        int unsigned errs_before;
        string       kind;
        errs_before = error_count;
        kind = tbl_write[idx] ? "write" : "read";
        wait_for(1'b0, 2 * FRAME_CYCLES, cycles, seen);
        if (!seen) begin
            $display("ready_o did not return within %0d cycles", cycles);
            error_count++;
        end else begin
            cmd_valid = 1'b1;
            cmd_write = tbl_write[idx];
            cmd_addr  = tbl_addr[idx];
            wr_data   = tbl_wdata[idx];
            @(negedge clk);
            cmd_valid = 1'b0;
            check_bit("ready_o after strobe", ready, 1'b0);
            check_bit("cs_n_o after strobe", cs_n, 1'b0);
            if (tbl_poke[idx]) begin
                // Master is busy, so this write must be dropped.
                cmd_valid = 1'b1;
                cmd_write = 1'b1;
                cmd_addr  = POKE_ADDR;
                wr_data   = POKE_DATA;
                @(negedge clk);
                cmd_valid = 1'b0;
            end
            wait_for(1'b1, 2 * FRAME_CYCLES, cycles, seen);
            if (!seen) begin
                $display("done_o did not rise within %0d cycles", cycles);
                error_count++;
            end else begin
                check_bit("cs_n_o at done", cs_n, 1'b1);
                if (!tbl_write[idx]) begin
                    check_word("rd_data_o", rd_data, tbl_expect[idx]);
                end
                @(negedge clk);
                check_bit("done_o after pulse", done, 1'b0);
                check_bit("ready_o after done", ready, 1'b1);
            end
        end
        finish_test($sformatf("%s addr %h", kind, tbl_addr[idx]), errs_before);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int unsigned cycles;
        logic        seen;
        int unsigned errs_before;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = '0;
        wr_data   = '0;
        build_table();
        fill_expected();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Reset state, then the power-up wait and init length.
        errs_before = error_count;
        @(negedge clk);
        check_bit("ready_o after reset", ready, 1'b0);
        check_bit("done_o after reset", done, 1'b0);
        check_bit("sclk_o after reset", sclk, 1'b0);
        check_bit("cs_n_o after reset", cs_n, 1'b1);
        check_bit("mosi_o after reset", mosi, 1'b0);
        wait_for(1'b0, 2 * INIT_CYCLES, cycles, seen);
        if (!seen) begin
            $display("ready_o never rose after the power-up sequence");
            error_count++;
        end
        check_bit("ready_o held through init", (cycles + 1 >= READY_MIN), 1'b1);
        finish_test("reset and power-up", errs_before);

        // Init clocks as seen by the slave.
        errs_before = error_count;
        check_word("init clock count", init_edges, 32'(INIT_CLOCKS));
        check_word("init half period", high_ns / CLK_PERIOD, 32'(DIV_SLOW));
        finish_test("init clocks", errs_before);

        for (int unsigned i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end

        // The busy strobe must not add a done pulse.
        errs_before = error_count;
        repeat (4) @(negedge clk);
        check_word("done_o pulse count", 32'(done_seen), 32'(NUM_TESTS));
        finish_test("done count", errs_before);

        $display("Tests run %0d, failed %0d, check failures %0d", test_count, test_fails,
                 error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
